// ==== src/debug_pkg.sv ====
package debug_pkg;

    //////////////////////////////////////////////////
    // Base types.
    //////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;                // One UART byte.
    typedef logic [31:0] word_t;                // Instruction or dump word.

    localparam word_t HALT_WORD  = '1;          // End of program marker.
    localparam byte_t READY_BYTE = 8'h01;       // Sent after the soft reset.

    //////////////////////////////////////////////////
    // Host commands and control states.
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        CMD_NONE,                               // No byte this cycle.
        CMD_RESET,                              // 0x00.
        CMD_LOAD,                               // 0x01.
        CMD_RUN,                                // 0x03.
        CMD_STEP,                               // 0x07.
        CMD_ACK,                                // 0x08, 0x10, 0x18, 0x20.
        CMD_OTHER
    } host_cmd_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SOFT_RESET,
        ST_WAIT_HOST,
        ST_LOAD,
        ST_WAIT_START,
        ST_RUN,
        ST_DUMP
    } ctrl_state_t;

    //////////////////////////////////////////////////
    // Bundles between the blocks.
    //////////////////////////////////////////////////

    typedef struct packed {
        logic      valid;                       // One-cycle byte strobe.
        byte_t     data;
        host_cmd_t cmd;
    } rx_event_t;

    typedef struct packed {
        logic  start;                           // Level request to the UART.
        byte_t data;
    } tx_req_t;

    typedef struct packed {
        logic  write;                           // Single-cycle write pulse.
        word_t data;
    } prog_write_t;

endpackage

// ==== src/rx_command_decoder.sv ====
module rx_command_decoder (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_rx_done,
    input  debug_pkg::byte_t      i_data_rx,
    output debug_pkg::rx_event_t  o_rx_event
);

    localparam debug_pkg::byte_t BYTE_RESET = 8'h00;
    localparam debug_pkg::byte_t BYTE_LOAD  = 8'h01;
    localparam debug_pkg::byte_t BYTE_RUN   = 8'h03;
    localparam debug_pkg::byte_t BYTE_STEP  = 8'h07;
    localparam debug_pkg::byte_t BYTE_ACK0  = 8'h08;
    localparam debug_pkg::byte_t BYTE_ACK1  = 8'h10;
    localparam debug_pkg::byte_t BYTE_ACK2  = 8'h18;
    localparam debug_pkg::byte_t BYTE_ACK3  = 8'h20;

    logic rx_done_q;                            // Done level of the last cycle.
    logic rx_fall;

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            rx_done_q <= 1'b0;
        end else begin
            rx_done_q <= i_rx_done;
        end
    end

    assign rx_fall = rx_done_q & ~i_rx_done;    // Falling edge of done.

    always_comb begin
        o_rx_event.valid = rx_fall;
        o_rx_event.data  = i_data_rx;
        if (!rx_fall) begin
            o_rx_event.cmd = debug_pkg::CMD_NONE;
        end else begin
            case (i_data_rx)
                BYTE_RESET: o_rx_event.cmd = debug_pkg::CMD_RESET;
                BYTE_LOAD:  o_rx_event.cmd = debug_pkg::CMD_LOAD;
                BYTE_RUN:   o_rx_event.cmd = debug_pkg::CMD_RUN;
                BYTE_STEP:  o_rx_event.cmd = debug_pkg::CMD_STEP;
                BYTE_ACK0, BYTE_ACK1, BYTE_ACK2, BYTE_ACK3: o_rx_event.cmd = debug_pkg::CMD_ACK;
                default:    o_rx_event.cmd = debug_pkg::CMD_OTHER;
            endcase
        end
    end

endmodule

// ==== src/program_loader.sv ====
module program_loader #(
    parameter int PROG_ADDR_WIDTH = 10
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_load_active,
    input  debug_pkg::rx_event_t        i_rx_event,
    output debug_pkg::prog_write_t      o_prog,
    output logic [PROG_ADDR_WIDTH-1:0]  o_prog_addr,
    output logic                        o_halt_seen
);

    logic [1:0]                 byte_cnt;       // Bytes of the current word.
    logic                       word_done;      // Fourth byte came in last cycle.
    logic [PROG_ADDR_WIDTH-1:0] addr_q;
    debug_pkg::word_t           word_q;         // Assembly register, MSB first.
    logic                       is_halt;
    logic                       take_byte;

    assign take_byte = i_load_active & i_rx_event.valid;
    assign is_halt   = (word_q == debug_pkg::HALT_WORD);

    //////////////////////////////////////////////////
    // Byte counter, word flag and write address.
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            byte_cnt  <= 2'd0;
            word_done <= 1'b0;
            addr_q    <= '0;
        end else if (!i_load_active) begin
            byte_cnt  <= 2'd0;                  // Start clean on every load.
            word_done <= 1'b0;
            addr_q    <= '0;
        end else begin
            word_done <= take_byte && (byte_cnt == 2'd3);
            if (take_byte) begin
                byte_cnt <= byte_cnt + 2'd1;
            end
            if (word_done && !is_halt) begin
                addr_q <= addr_q + 1'b1;        // Next slot after the write.
            end
        end
    end

    //////////////////////////////////////////////////
    // Shift register.
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (take_byte) begin
            word_q <= {word_q[23:0], i_rx_event.data};
        end
    end

    always_comb begin
        o_prog.write = word_done & ~is_halt;
        o_prog.data  = word_q;
    end

    assign o_prog_addr = addr_q;
    assign o_halt_seen = word_done & is_halt;   // HALT itself is never written.

endmodule

// ==== src/dump_serializer.sv ====
module dump_serializer #(
    parameter  int DUMP_WORDS     = 12,
    localparam int DUMP_SEL_WIDTH = $clog2(DUMP_WORDS)
) (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_dump_active,
    input  debug_pkg::rx_event_t       i_rx_event,
    input  debug_pkg::word_t           i_dump_word,
    output logic [DUMP_SEL_WIDTH-1:0]  o_dump_select,
    output debug_pkg::tx_req_t         o_tx,
    output logic                       o_done
);

    logic [DUMP_SEL_WIDTH-1:0] word_idx;
    logic [1:0]                byte_pos;        // 0 is the most significant byte.
    logic [2:0]                ack_num;
    logic                      ack_ok;
    logic                      last_byte;

    assign ack_num   = {1'b0, byte_pos} + 3'd1;
    assign ack_ok    = i_dump_active && (i_rx_event.cmd == debug_pkg::CMD_ACK)
                       && (i_rx_event.data == {2'b00, ack_num, 3'b000}); // 0x08 per step.
    assign last_byte = (byte_pos == 2'd3)
                       && (word_idx == DUMP_SEL_WIDTH'(DUMP_WORDS - 1));

    always_ff @(posedge i_clock) begin
        if (!i_reset || !i_dump_active) begin
            word_idx <= '0;
            byte_pos <= 2'd0;
        end else if (ack_ok) begin
            byte_pos <= byte_pos + 2'd1;        // Wraps to the next word.
            if (last_byte) begin
                word_idx <= '0;
            end else if (byte_pos == 2'd3) begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    always_comb begin
        o_tx.start = i_dump_active;
        case (byte_pos)
            2'd0:    o_tx.data = i_dump_word[31:24];
            2'd1:    o_tx.data = i_dump_word[23:16];
            2'd2:    o_tx.data = i_dump_word[15:8];
            default: o_tx.data = i_dump_word[7:0];
        endcase
    end

    assign o_dump_select = word_idx;
    assign o_done        = ack_ok & last_byte;

endmodule

// ==== src/debug_control.sv ====
module debug_control (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  debug_pkg::rx_event_t  i_rx_event,
    input  logic                  i_soft_reset_ack,
    input  logic                  i_halt,
    input  logic                  i_halt_seen,
    input  logic                  i_dump_done,
    input  debug_pkg::tx_req_t    i_dump_tx,
    output debug_pkg::tx_req_t    o_tx,
    output logic                  o_soft_reset,
    output logic                  o_load_active,
    output logic                  o_dump_active,
    output logic                  o_enable_pc,
    output logic                  o_enable_pipeline
);

    debug_pkg::ctrl_state_t state_q;
    debug_pkg::ctrl_state_t state_d;
    logic                   step_mode_q;        // Set for single-step runs.
    logic                   halted_q;           // HALT reached in this run.
    logic                   run_enable;
    logic                   start_cmd;

    assign start_cmd = (i_rx_event.cmd == debug_pkg::CMD_RUN)
                       || (i_rx_event.cmd == debug_pkg::CMD_STEP);

    //////////////////////////////////////////////////
    // State register and run flags.
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state_q     <= debug_pkg::ST_IDLE;
            step_mode_q <= 1'b0;
            halted_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == debug_pkg::ST_WAIT_START) begin
                halted_q <= 1'b0;
                if (start_cmd) begin
                    step_mode_q <= (i_rx_event.cmd == debug_pkg::CMD_STEP);
                end
            end else if (state_q == debug_pkg::ST_RUN || state_q == debug_pkg::ST_DUMP) begin
                halted_q <= halted_q | i_halt;
            end
        end
    end

    //////////////////////////////////////////////////
    // Next state.
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            debug_pkg::ST_IDLE: begin
                if (i_rx_event.cmd == debug_pkg::CMD_RESET) state_d = debug_pkg::ST_SOFT_RESET;
            end
            debug_pkg::ST_SOFT_RESET: begin
                if (!i_soft_reset_ack) state_d = debug_pkg::ST_WAIT_HOST;
            end
            debug_pkg::ST_WAIT_HOST: begin
                if (i_rx_event.cmd == debug_pkg::CMD_LOAD) state_d = debug_pkg::ST_LOAD;
            end
            debug_pkg::ST_LOAD: begin
                if (i_halt_seen) state_d = debug_pkg::ST_WAIT_START;
            end
            debug_pkg::ST_WAIT_START: begin
                if (start_cmd) state_d = debug_pkg::ST_RUN;
            end
            debug_pkg::ST_RUN: begin
                if (step_mode_q || i_halt) state_d = debug_pkg::ST_DUMP; // One cycle in step mode.
            end
            debug_pkg::ST_DUMP: begin
                if (i_dump_done) begin
                    if (!step_mode_q || halted_q || i_halt) begin
                        state_d = debug_pkg::ST_IDLE;
                    end else begin
                        state_d = debug_pkg::ST_WAIT_START;
                    end
                end
            end
            default: state_d = debug_pkg::ST_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // Level outputs.
    //////////////////////////////////////////////////

    assign run_enable = (state_q == debug_pkg::ST_RUN) && (step_mode_q || !i_halt);

    always_comb begin
        case (state_q)
            debug_pkg::ST_WAIT_HOST: o_tx = '{start: 1'b1, data: debug_pkg::READY_BYTE};
            debug_pkg::ST_DUMP:      o_tx = i_dump_tx;
            default:                 o_tx = '0;
        endcase
    end

    assign o_soft_reset      = (state_q != debug_pkg::ST_SOFT_RESET); // Active low.
    assign o_load_active     = (state_q == debug_pkg::ST_LOAD);
    assign o_dump_active     = (state_q == debug_pkg::ST_DUMP);
    assign o_enable_pc       = run_enable;
    assign o_enable_pipeline = run_enable;

endmodule

// ==== src/debug_top.sv ====
module debug_top #(
    parameter  int PROG_ADDR_WIDTH = 10,
    parameter  int DUMP_WORDS      = 12,
    localparam int DUMP_SEL_WIDTH  = $clog2(DUMP_WORDS)
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_rx_done,
    input  debug_pkg::byte_t            i_data_rx,
    input  logic                        i_soft_reset_ack,
    input  logic                        i_halt,
    input  debug_pkg::word_t            i_dump_word,
    output debug_pkg::tx_req_t          o_tx,
    output logic                        o_soft_reset,
    output debug_pkg::prog_write_t      o_prog,
    output logic [PROG_ADDR_WIDTH-1:0]  o_prog_addr,
    output logic                        o_enable_pc,
    output logic                        o_enable_pipeline,
    output logic [DUMP_SEL_WIDTH-1:0]   o_dump_select
);

    debug_pkg::rx_event_t rx_event;             // Shared by all three consumers.
    debug_pkg::tx_req_t   dump_tx;
    logic                 load_active;
    logic                 dump_active;
    logic                 halt_seen;
    logic                 dump_done;

    rx_command_decoder rx_command_decoder_i (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rx_done  (i_rx_done),
        .i_data_rx  (i_data_rx),
        .o_rx_event (rx_event)
    );

    program_loader #(
        .PROG_ADDR_WIDTH (PROG_ADDR_WIDTH)
    ) program_loader_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_load_active (load_active),
        .i_rx_event    (rx_event),
        .o_prog        (o_prog),
        .o_prog_addr   (o_prog_addr),
        .o_halt_seen   (halt_seen)
    );

    dump_serializer #(
        .DUMP_WORDS (DUMP_WORDS)
    ) dump_serializer_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_dump_active (dump_active),
        .i_rx_event    (rx_event),
        .i_dump_word   (i_dump_word),
        .o_dump_select (o_dump_select),
        .o_tx          (dump_tx),
        .o_done        (dump_done)
    );

    debug_control debug_control_i (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx_event        (rx_event),
        .i_soft_reset_ack  (i_soft_reset_ack),
        .i_halt            (i_halt),
        .i_halt_seen       (halt_seen),
        .i_dump_done       (dump_done),
        .i_dump_tx         (dump_tx),
        .o_tx              (o_tx),
        .o_soft_reset      (o_soft_reset),
        .o_load_active     (load_active),
        .o_dump_active     (dump_active),
        .o_enable_pc       (o_enable_pc),
        .o_enable_pipeline (o_enable_pipeline)
    );

endmodule

// ==== dv/debug_tb_host.svh ====
//////////////////////////////////////////////////
// Random source and basic host actions.
//////////////////////////////////////////////////

function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] result;
    logic        feedback;
    result = '0;
    for (int i = 0; i < count; i++) begin
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        result     = {result[30:0], feedback};      // One step per bit taken.
    end
    return result;
endfunction

function automatic debug_pkg::word_t random_word();
    debug_pkg::word_t w;
    w = lfsr_bits(32);
    while (w == debug_pkg::HALT_WORD) begin
        w = lfsr_bits(32);                          // HALT would end the program early.
    end
    return w;
endfunction

task automatic fill_registers();
    foreach (dump_regs[i]) begin
        dump_regs[i] = lfsr_bits(32);
    end
endtask

task automatic expect_equal(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
        errors++;
        $display("CHECK FAILED %s %s: expected %h, actual %h",
                 test_name, what, expected, actual);
    end
endtask

task automatic expect_enables(input logic expected);
    expect_equal("pc enable", 32'(expected), 32'(o_enable_pc));
    expect_equal("pipeline enable", 32'(expected), 32'(o_enable_pipeline));
endtask

task automatic send_byte(input debug_pkg::byte_t value);
    @(negedge i_clock);
    i_data_rx = value;
    i_rx_done = 1'b1;
    repeat (2) @(negedge i_clock);
    i_rx_done = 1'b0;                               // Byte is taken on this falling edge.
    @(negedge i_clock);
endtask

task automatic send_word(input debug_pkg::word_t value);
    for (int k = 0; k < 4; k++) begin
        send_byte(value[31-8*k -: 8]);              // Most significant byte first.
    end
endtask

//////////////////////////////////////////////////
// Test sequences.
//////////////////////////////////////////////////

task automatic reset_and_load();
    int               hold;
    debug_pkg::word_t w;
    test_name = "soft reset";
    send_byte(8'h00);
    hold = 3 + int'(lfsr_bits(3));
    repeat (hold) begin
        expect_equal("soft reset while ack high", 0, 32'(o_soft_reset));
        @(negedge i_clock);
    end
    i_soft_reset_ack = 1'b0;
    @(negedge i_clock);
    i_soft_reset_ack = 1'b1;
    expect_equal("soft reset released", 1, 32'(o_soft_reset));
    repeat (3) begin
        expect_equal("ready start", 1, 32'(o_tx.start));
        expect_equal("ready byte", 32'(debug_pkg::READY_BYTE), 32'(o_tx.data));
        @(negedge i_clock);
    end
    send_byte(8'h01);
    expect_equal("tx start after load command", 0, 32'(o_tx.start));
    test_name = "program load";
    sent_words.delete();
    written_words.delete();
    written_addrs.delete();
    repeat (8) begin
        w = random_word();
        sent_words.push_back(w);
        send_word(w);
    end
    send_word(debug_pkg::HALT_WORD);
    repeat (2) @(negedge i_clock);
    expect_equal("write count", 8, 32'(written_words.size()));
    foreach (written_words[i]) begin
        expect_equal("write address", 32'(i), 32'(written_addrs[i]));
        expect_equal("write data", sent_words[i], written_words[i]);
    end
endtask

task automatic dump_and_check();
    debug_pkg::byte_t expected;
    test_name = "register dump";
    for (int w = 0; w < DUMP_WORDS; w++) begin
        for (int k = 0; k < 4; k++) begin
            expected = dump_regs[w][31-8*k -: 8];
            expect_equal("dump start", 1, 32'(o_tx.start));
            expect_equal("dump select", 32'(w), 32'(o_dump_select));
            expect_equal("dump byte", 32'(expected), 32'(o_tx.data));
            if (lfsr_bits(2) == 0) begin
                send_byte(8'(8 * (((k + 1) % 4) + 1)));  // Ack of another position.
                expect_equal("byte after wrong ack", 32'(expected), 32'(o_tx.data));
                expect_equal("select after wrong ack", 32'(w), 32'(o_dump_select));
            end
            send_byte(8'(8 * (k + 1)));
        end
    end
endtask

task automatic continuous_run();
    int run_cycles;
    test_name = "continuous run";
    fill_registers();
    send_byte(8'h03);
    run_cycles = 4 + int'(lfsr_bits(4));
    repeat (run_cycles) begin
        expect_enables(1'b1);
        @(negedge i_clock);
    end
    i_halt = 1'b1;
    @(negedge i_clock);
    i_halt = 1'b0;
    expect_enables(1'b0);
    dump_and_check();
    test_name = "idle after dump";
    expect_equal("tx start after dump", 0, 32'(o_tx.start));
    send_byte(8'h07);                               // Must be ignored in idle.
    repeat (3) begin
        expect_enables(1'b0);
        expect_equal("tx start in idle", 0, 32'(o_tx.start));
        @(negedge i_clock);
    end
endtask

task automatic step_run();
    test_name = "step run";
    fill_registers();
    send_byte(8'h07);
    expect_enables(1'b1);
    @(negedge i_clock);
    expect_enables(1'b0);                           // Exactly one cycle.
    expect_equal("no soft reset in step mode", 1, 32'(o_soft_reset));
    dump_and_check();
    test_name = "step run";
    expect_equal("tx start after step dump", 0, 32'(o_tx.start));
endtask

// ==== dv/debug_tb.sv ====
module debug_tb;

    localparam int PROG_ADDR_WIDTH = 10;
    localparam int DUMP_WORDS      = 12;
    localparam int DUMP_SEL_WIDTH  = $clog2(DUMP_WORDS);
    localparam int HOST_BYTES      = 400;                  // Two loads, three dumps, stray acks.
    localparam int CYCLE_LIMIT     = 50 * HOST_BYTES;      // About 4 cycles per byte needed.

    logic                        i_clock = 1'b0;
    logic                        i_reset;
    logic                        i_rx_done;
    debug_pkg::byte_t            i_data_rx;
    logic                        i_soft_reset_ack;
    logic                        i_halt;
    debug_pkg::word_t            i_dump_word;
    debug_pkg::tx_req_t          o_tx;
    logic                        o_soft_reset;
    debug_pkg::prog_write_t      o_prog;
    logic [PROG_ADDR_WIDTH-1:0]  o_prog_addr;
    logic                        o_enable_pc;
    logic                        o_enable_pipeline;
    logic [DUMP_SEL_WIDTH-1:0]   o_dump_select;

    debug_pkg::word_t            dump_regs [DUMP_WORDS];   // Register file model.
    debug_pkg::word_t            sent_words[$];
    debug_pkg::word_t            written_words[$];         // Program memory model.
    int                          written_addrs[$];
    logic [31:0]                 lfsr_state;
    string                       test_name;
    int                          checks;
    int                          errors;
    int                          cycles;

    debug_top #(
        .PROG_ADDR_WIDTH (PROG_ADDR_WIDTH),
        .DUMP_WORDS      (DUMP_WORDS)
    ) debug_top_i (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx_done         (i_rx_done),
        .i_data_rx         (i_data_rx),
        .i_soft_reset_ack  (i_soft_reset_ack),
        .i_halt            (i_halt),
        .i_dump_word       (i_dump_word),
        .o_tx              (o_tx),
        .o_soft_reset      (o_soft_reset),
        .o_prog            (o_prog),
        .o_prog_addr       (o_prog_addr),
        .o_enable_pc       (o_enable_pc),
        .o_enable_pipeline (o_enable_pipeline),
        .o_dump_select     (o_dump_select)
    );

    `include "debug_tb_host.svh"

    assign i_dump_word = dump_regs[o_dump_select];         // Answers the select.

    initial begin
        forever begin
            #20 i_clock = ~i_clock;
        end
    end

    always @(posedge i_clock) begin
        if (i_reset && o_prog.write) begin
            written_words.push_back(o_prog.data);
            written_addrs.push_back(int'(o_prog_addr));
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge i_clock);
            cycles++;
        end
        $display("Timeout after %0d cycles, the test sequences did not finish.", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Rules that hold on every cycle.
    //////////////////////////////////////////////////

    assert property (@(posedge i_clock) disable iff (!i_reset)
                     o_prog.write |-> (o_prog.data != debug_pkg::HALT_WORD))
        else begin
            errors++;
            $display("CHECK FAILED %s halt write: expected data other than %h, actual %h",
                     test_name, debug_pkg::HALT_WORD, o_prog.data);
        end

    assert property (@(posedge i_clock) disable iff (!i_reset)
                     o_enable_pc == o_enable_pipeline)
        else begin
            errors++;
            $display("CHECK FAILED %s enable pair: expected %b, actual %b",
                     test_name, o_enable_pc, o_enable_pipeline);
        end

    assert property (@(posedge i_clock) disable iff (!i_reset)
                     o_tx.start |-> !o_enable_pc)
        else begin
            errors++;
            $display("CHECK FAILED %s enable while sending: expected 0, actual %b",
                     test_name, o_enable_pc);
        end

    assert property (@(posedge i_clock) disable iff (!i_reset)
                     (!o_soft_reset && i_soft_reset_ack) |=> !o_soft_reset)
        else begin
            errors++;
            $display("CHECK FAILED %s soft reset hold: expected 0, actual %b",
                     test_name, o_soft_reset);
        end

    //////////////////////////////////////////////////
    // Main sequence.
    //////////////////////////////////////////////////

    initial begin
        lfsr_state       = 32'h8de9;
        checks           = 0;
        errors           = 0;
        test_name        = "after reset";
        i_reset          = 1'b0;
        i_rx_done        = 1'b0;
        i_data_rx        = '0;
        i_soft_reset_ack = 1'b1;
        i_halt           = 1'b0;
        fill_registers();
        repeat (4) @(negedge i_clock);
        i_reset = 1'b1;
        @(negedge i_clock);
        expect_equal("soft reset", 1, 32'(o_soft_reset));
        expect_equal("tx start", 0, 32'(o_tx.start));
        expect_enables(1'b0);
        expect_equal("program write", 0, 32'(o_prog.write));
        reset_and_load();
        continuous_run();
        reset_and_load();                                  // Idle accepts a new reset.
        step_run();
        step_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+dv
src/debug_pkg.sv
src/rx_command_decoder.sv
src/program_loader.sv
src/dump_serializer.sv
src/debug_control.sv
src/debug_top.sv
dv/debug_tb.sv

// ==== Makefile ====
SOURCES := $(wildcard src/*.sv dv/*.sv dv/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vdebug_tb: files.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module debug_tb

run: obj_dir/Vdebug_tb
	obj_dir/Vdebug_tb | awk '{ print } /^Simulation PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
